/* common/cmul_pkg.sv */
package cmul_pkg;

   // Operand and result widths.
   localparam int OP_W   = 8;            // One signed operand byte.
   localparam int IN_W   = 4 * OP_W;     // Input word holds ar, ai, br and bi.
   localparam int PROD_W = 2 * OP_W;     // Full signed 8x8 product.
   localparam int RES_W  = PROD_W + 1;   // Difference of two products needs one more bit.

   // Field positions inside the input word.
   // Byte 0 is ar and byte 3 is bi.
   localparam int AR_LSB = 0;
   localparam int AI_LSB = AR_LSB + OP_W;
   localparam int BR_LSB = AI_LSB + OP_W;
   localparam int BI_LSB = BR_LSB + OP_W;

   // Multiplier pipeline registers in each product lane.
   // The operand register in front of them is extra.
   localparam int LANE_LAT = 3;

endpackage

/* design/cmul_re_top.sv */
`timescale 1ns/1ns

module cmul_re_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       in_valid,
   input  logic [cmul_pkg::IN_W-1:0]  in_data,
   output logic                       in_ready,
   output logic                       out_valid,
   output logic [cmul_pkg::RES_W-1:0] out_data,
   input  logic                       out_ready
);

   // Input word fields.
   logic [cmul_pkg::OP_W-1:0]   ar;
   logic [cmul_pkg::OP_W-1:0]   ai;
   logic [cmul_pkg::OP_W-1:0]   br;
   logic [cmul_pkg::OP_W-1:0]   bi;

   logic                        issue;
   logic                        pop;
   logic                        rr_ready;
   logic                        ii_ready;
   logic                        rr_valid;
   logic                        ii_valid;
   logic [cmul_pkg::PROD_W-1:0] rr_data;
   logic [cmul_pkg::PROD_W-1:0] ii_data;

   assign ar = in_data[cmul_pkg::AR_LSB +: cmul_pkg::OP_W];
   assign ai = in_data[cmul_pkg::AI_LSB +: cmul_pkg::OP_W];
   assign br = in_data[cmul_pkg::BR_LSB +: cmul_pkg::OP_W];
   assign bi = in_data[cmul_pkg::BI_LSB +: cmul_pkg::OP_W];

   // ar * br.
   product_lane #(.LATENCY(cmul_pkg::LANE_LAT)) u_rr (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .a          (ar),
      .b          (br),
      .din_ready  (rr_ready),
      .pop        (pop),
      .dout_valid (rr_valid),
      .dout_data  (rr_data)
   );

   // ai * bi.
   product_lane #(.LATENCY(cmul_pkg::LANE_LAT)) u_ii (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .a          (ai),
      .b          (bi),
      .din_ready  (ii_ready),
      .pop        (pop),
      .dout_valid (ii_valid),
      .dout_data  (ii_data)
   );

   re_join u_join (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .rr_ready  (rr_ready),
      .ii_ready  (ii_ready),
      .in_ready  (in_ready),
      .issue     (issue),
      .rr_valid  (rr_valid),
      .rr_data   (rr_data),
      .ii_valid  (ii_valid),
      .ii_data   (ii_data),
      .pop       (pop),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready)
   );

endmodule

/* design/re_join.sv */
`timescale 1ns/1ns

module re_join (
   input  logic                        clk,
   input  logic                        rst,

   // Input side, shared by both lanes.
   input  logic                        in_valid,
   input  logic                        rr_ready,
   input  logic                        ii_ready,
   output logic                        in_ready,
   output logic                        issue,

   // Lane results.
   input  logic                        rr_valid,
   input  logic [cmul_pkg::PROD_W-1:0] rr_data,
   input  logic                        ii_valid,
   input  logic [cmul_pkg::PROD_W-1:0] ii_data,
   output logic                        pop,

   // Output register.
   output logic                        out_valid,
   output logic [cmul_pkg::RES_W-1:0]  out_data,
   input  logic                        out_ready
);

   logic                       both_valid;   // A matched pair waits at the lane heads.
   logic                       out_free;     // Output register can take a value this cycle.
   logic [cmul_pkg::RES_W-1:0] rr_ext;
   logic [cmul_pkg::RES_W-1:0] ii_ext;
   logic [cmul_pkg::RES_W-1:0] diff;

   // A word goes to both lanes or to neither, so they stay in step.
   assign in_ready = rr_ready && ii_ready;
   assign issue    = in_valid && in_ready;

   assign both_valid = rr_valid && ii_valid;
   assign out_free   = !out_valid || out_ready;   // Empty, or drained at this edge.

   // Both lanes are popped together.
   assign pop = both_valid && out_free;

   // Sign extend both products before the subtraction.
   assign rr_ext = {rr_data[cmul_pkg::PROD_W-1], rr_data};
   assign ii_ext = {ii_data[cmul_pkg::PROD_W-1], ii_data};
   assign diff   = rr_ext - ii_ext;   // Real part ar*br - ai*bi.

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (pop) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;          // Read with nothing new behind it.
      end
   end

   // Held while out_valid is high and out_ready is low.
   always_ff @(posedge clk) begin
      if (pop) begin
         out_data <= diff;
      end
   end

endmodule

/* lane/fixed_latency_decoupler.sv */
`timescale 1ns/1ns

module fixed_latency_decoupler #(
   parameter int DATA_W  = 16,    // Width of the datapath result.
   parameter int LATENCY = 3      // Registers between din_valid and dout_data_in.
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              din_valid,
   input  logic [DATA_W-1:0] dout_data_in,
   output logic              din_ready,
   output logic              dout_valid,
   output logic [DATA_W-1:0] dout_data,
   input  logic              dout_ready
);

   // Catch buffer is sized so every result in flight has a slot.
   localparam int PTR_W = $clog2(LATENCY + 1);
   localparam int DEPTH = 2 ** PTR_W;

   localparam logic [PTR_W:0]   PTR_ONE = 1;
   localparam logic [PTR_W-1:0] CNT_ONE = 1;

   logic [LATENCY-1:0] valid_pipe;          // One flag per datapath stage.
   logic               land;                // Result at dout_data_in is valid now.
   logic               wr_en;
   logic               rd_en;

   logic [DATA_W-1:0]  mem [DEPTH];

   // Pointers carry one lap bit above the address bits.
   logic [PTR_W:0]     w_ptr;
   logic [PTR_W:0]     r_ptr;
   logic [PTR_W:0]     w_ptr_next;
   logic [PTR_W:0]     r_ptr_next;
   logic [PTR_W-1:0]   cnt_next;            // Wraps to zero when full.
   logic               full;
   logic               full_next;

   assign land = valid_pipe[LATENCY-1];

   // Same address on a different lap means every entry is taken.
   assign full = (w_ptr[PTR_W-1:0] == r_ptr[PTR_W-1:0]) &&
                 (w_ptr[PTR_W] != r_ptr[PTR_W]);

   assign wr_en = land && !full;
   assign rd_en = dout_ready && dout_valid;

   assign w_ptr_next = wr_en ? w_ptr + PTR_ONE : w_ptr;
   assign r_ptr_next = rd_en ? r_ptr + PTR_ONE : r_ptr;

   // Occupancy after this edge.
   assign cnt_next  = w_ptr_next[PTR_W-1:0] - r_ptr_next[PTR_W-1:0];
   assign full_next = (w_ptr_next[PTR_W-1:0] == r_ptr_next[PTR_W-1:0]) &&
                      (w_ptr_next[PTR_W] != r_ptr_next[PTR_W]);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
         w_ptr      <= '0;
         r_ptr      <= '0;
         dout_valid <= 1'b0;
         din_ready  <= 1'b1;   // Empty buffer takes new issues at once.
      end else begin
         valid_pipe[0] <= din_valid;
         for (int i = 1; i < LATENCY; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end

         w_ptr <= w_ptr_next;
         r_ptr <= r_ptr_next;

         dout_valid <= (w_ptr_next != r_ptr_next);

         // Look ahead. With at most one entry left, the results still in the
         // delay line plus one new issue fit in the remaining slots.
         din_ready <= (cnt_next <= CNT_ONE) && !full_next;
      end
   end

   // Result storage.
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[w_ptr[PTR_W-1:0]] <= dout_data_in;
      end
   end

   assign dout_data = mem[r_ptr[PTR_W-1:0]];   // Head of the buffer.

endmodule

/* lane/product_lane.sv */
`timescale 1ns/1ns

module product_lane #(
   parameter int LATENCY = cmul_pkg::LANE_LAT   // Multiplier pipeline registers.
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        issue,
   input  logic [cmul_pkg::OP_W-1:0]   a,
   input  logic [cmul_pkg::OP_W-1:0]   b,
   output logic                        din_ready,
   input  logic                        pop,
   output logic                        dout_valid,
   output logic [cmul_pkg::PROD_W-1:0] dout_data
);

   // Operand register plus the multiplier stages.
   // The decoupler must see this full depth to pair each issue with its product.
   localparam int PIPE_DEPTH = LATENCY + 1;

   logic signed [cmul_pkg::OP_W-1:0]   a_q;
   logic signed [cmul_pkg::OP_W-1:0]   b_q;
   logic signed [cmul_pkg::PROD_W-1:0] prod_pipe [LATENCY];
   logic        [cmul_pkg::PROD_W-1:0] prod_out;

   // Operands are captured every cycle.
   // Only words with issue high are tracked downstream.
   always_ff @(posedge clk) begin
      a_q <= a;
      b_q <= b;
   end

   // Signed multiply in the first stage, then plain delay stages.
   // Nothing here stalls. Back-pressure ends in the decoupler buffer.
   always_ff @(posedge clk) begin
      prod_pipe[0] <= a_q * b_q;   // Both operands signed, so the product is too.
      for (int i = 1; i < LATENCY; i++) begin
         prod_pipe[i] <= prod_pipe[i-1];
      end
   end

   assign prod_out = prod_pipe[LATENCY-1];

   // Valid tracking and catch buffer.
   fixed_latency_decoupler #(
      .DATA_W  (cmul_pkg::PROD_W),
      .LATENCY (PIPE_DEPTH)
   ) u_dec (
      .clk          (clk),
      .rst          (rst),
      .din_valid    (issue),
      .dout_data_in (prod_out),
      .din_ready    (din_ready),
      .dout_valid   (dout_valid),
      .dout_data    (dout_data),
      .dout_ready   (pop)
   );

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal --top-module cmul_re_tb \
   -f sources.f -o cmul_re_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/cmul_re_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* sources.f */
common/cmul_pkg.sv
lane/fixed_latency_decoupler.sv
lane/product_lane.sv
design/re_join.sv
design/cmul_re_top.sv
tests/cmul_re_sva.sv
tests/cmul_re_tb.sv

/* tests/cmul_re_sva.sv */
`timescale 1ns/1ns

module cmul_re_sva (
   input logic                       clk,
   input logic                       rst,
   input logic                       in_ready,
   input logic                       out_valid,
   input logic [cmul_pkg::RES_W-1:0] out_data,
   input logic                       out_ready
);

   // Stalled output keeps its word.
   a_out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("out_data or out_valid changed while the output was stalled");

   a_rst_clear: assert property (@(posedge clk)
      rst |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

   // Empty lane buffers take a word at once.
   a_rst_ready: assert property (@(posedge clk)
      rst |=> in_ready)
      else $error("in_ready low in the cycle after reset");

endmodule

bind cmul_re_top cmul_re_sva u_sva (
   .clk       (clk),
   .rst       (rst),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_data  (out_data),
   .out_ready (out_ready)
);

/* tests/cmul_re_tb.sv */
`timescale 1ns/1ns

module cmul_re_tb;

   localparam int MAX_CYCLES = 20000;                 // Roughly 700 words in all.
   localparam int VALID_LAT  = cmul_pkg::LANE_LAT + 2; // Acceptance edge to out_valid rise.

   logic                       clk;
   logic                       rst;
   logic                       in_valid;
   logic [cmul_pkg::IN_W-1:0]  in_data;
   logic                       in_ready;
   logic                       out_valid;
   logic [cmul_pkg::RES_W-1:0] out_data;
   logic                       out_ready;

   integer seed;
   integer ready_seed;
   bit     ready_random;            // Random back-pressure on the output side.

   int cycle = 0;
   int value_errs = 0;
   int other_errs = 0;
   int timeout_errs = 0;
   int out_count = 0;
   int last_latency = 0;

   logic [cmul_pkg::RES_W-1:0] last_out;
   logic [cmul_pkg::RES_W-1:0] exp_q[$];   // Scoreboard, oldest word first.
   int                         acc_q[$];   // Acceptance cycle of each word.
   int                         out_cyc_q[$];

   cmul_re_top dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready)
   );

   always #4 clk = ~clk;

   // Real part of (ar + j*ai) * (br + j*bi).
   function automatic logic [cmul_pkg::RES_W-1:0] ref_re(input logic [cmul_pkg::IN_W-1:0] w);
      int ar;
      int ai;
      int br;
      int bi;
      int re;
      ar = $signed(w[cmul_pkg::AR_LSB +: cmul_pkg::OP_W]);
      ai = $signed(w[cmul_pkg::AI_LSB +: cmul_pkg::OP_W]);
      br = $signed(w[cmul_pkg::BR_LSB +: cmul_pkg::OP_W]);
      bi = $signed(w[cmul_pkg::BI_LSB +: cmul_pkg::OP_W]);
      re = ar * br - ai * bi;
      return re[cmul_pkg::RES_W-1:0];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         value_errs++;
         $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      end
   endtask

   task automatic report_and_finish();
      $display("Errors: %0d value, %0d other, %0d timeout", value_errs, other_errs,
               timeout_errs);
      if (value_errs + other_errs + timeout_errs == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   endtask

   // Cycle count and watchdog.
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle == MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
         timeout_errs++;
         report_and_finish();
      end
   end

   // Every accepted word pushes its expected result.
   always @(posedge clk) begin
      if (!rst && in_valid && in_ready) begin
         exp_q.push_back(ref_re(in_data));
         acc_q.push_back(cycle);
      end
   end

   // Compare each output transfer with the scoreboard head.
   always @(posedge clk) begin
      if (!rst && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            other_errs++;
            $display("Output transfer at cycle %0d with no word waiting for it.", cycle);
         end else begin
            check_value("out_data", out_data, exp_q.pop_front());
            last_latency = cycle - acc_q.pop_front();
         end
         last_out = out_data;
         out_cyc_q.push_back(cycle);
         out_count++;
      end
   end

   // Output back-pressure.
   always @(negedge clk) begin
      if (ready_random) begin
         out_ready = $random(ready_seed) & 1;
      end else begin
         out_ready = 1'b1;
      end
   end

   // Returns at the falling edge before the accepting rising edge.
   task automatic send_word(input logic [cmul_pkg::IN_W-1:0] w, input bit gaps);
      @(negedge clk);
      while (gaps && ($random(seed) & 3) == 0) begin
         in_valid = 1'b0;
         in_data  = $random(seed);   // Junk while idle.
         @(negedge clk);
      end
      in_valid = 1'b1;
      in_data  = w;
      while (!in_ready) begin
         @(negedge clk);
      end
   endtask

   task automatic stop_input();
      @(negedge clk);
      in_valid = 1'b0;
      in_data  = '0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (10) @(negedge clk);   // Room for any extra output to show up.
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst      = 1'b1;
      in_valid = 1'b0;
      repeat (8) @(negedge clk);
      exp_q.delete();
      acc_q.delete();
      rst = 1'b0;
   endtask

   task automatic test_single();
      send_word($random(seed), 1'b0);
      stop_input();
      wait_drain();
      // The word leaves on the edge after out_valid rises.
      check_value("latency", last_latency, VALID_LAT + 1);
   endtask

   task automatic test_stream();
      out_cyc_q.delete();
      for (int i = 0; i < 200; i++) begin
         send_word($random(seed), 1'b0);
      end
      stop_input();
      wait_drain();
      check_value("stream_count", out_cyc_q.size(), 200);
      check_value("stream_span", out_cyc_q[199] - out_cyc_q[0], 199);
   endtask

   task automatic test_random();
      int base;
      base         = out_count;
      ready_random = 1'b1;
      for (int i = 0; i < 300; i++) begin
         send_word($random(seed), 1'b1);
      end
      stop_input();
      wait_drain();
      ready_random = 1'b0;
      check_value("random_count", out_count - base, 300);
   endtask

   task automatic test_corners();
      logic [7:0] corner [3];
      corner[0] = 8'h80;
      corner[1] = 8'h7f;
      corner[2] = 8'h00;
      for (int a = 0; a < 3; a++) begin
         for (int b = 0; b < 3; b++) begin
            for (int c = 0; c < 3; c++) begin
               for (int d = 0; d < 3; d++) begin
                  send_word({corner[d], corner[c], corner[b], corner[a]}, 1'b0);
               end
            end
         end
      end
      stop_input();
      wait_drain();
      // Largest result, 16384 + 16256.
      send_word(32'h7f808080, 1'b0);
      stop_input();
      wait_drain();
      check_value("out_data", last_out, 17'h07f80);
      // Smallest result, -16256 - 16384.
      send_word(32'h807f8080, 1'b0);
      stop_input();
      wait_drain();
      check_value("out_data", last_out, 17'h18080);
   endtask

   task automatic test_reset_mid();
      ready_random = 1'b1;
      for (int i = 0; i < 40; i++) begin
         send_word($random(seed), 1'b1);
      end
      apply_reset();
      @(negedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("in_ready", in_ready, 1'b1);
      for (int i = 0; i < 60; i++) begin
         send_word($random(seed), 1'b1);
      end
      stop_input();
      wait_drain();
      ready_random = 1'b0;
   endtask

   initial begin
      seed         = 32'hacb2;
      ready_seed   = seed ^ 32'h5a5a;   // Separate stream for out_ready.
      clk          = 1'b0;
      rst          = 1'b1;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b1;
      ready_random = 1'b0;

      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_single();
      test_stream();
      test_random();
      test_corners();
      test_reset_mid();

      if (exp_q.size() != 0) begin
         other_errs++;
         $display("%0d expected results never came out.", exp_q.size());
      end
      report_and_finish();
   end

endmodule
